// ==== verilog/muldiv_pkg.sv ====
package muldiv_pkg;

	parameter int XLEN = 32;
	parameter int HALF_W = 16;
	parameter int ACC_W = 34; // One 17x17 product plus carries.
	parameter int CNT_W = 5;

	// Bit positions in the signed-mode field.
	parameter int SIGN_A_BIT = 0;
	parameter int SIGN_B_BIT = 1;

	typedef enum logic [1:0] {
		MD_OP_MULL = 2'd0,
		MD_OP_MULH = 2'd1,
		MD_OP_DIV  = 2'd2,
		MD_OP_REM  = 2'd3
	} md_op_e;

	typedef enum logic [2:0] {
		MD_IDLE        = 3'd0,
		MD_ABS_A       = 3'd1,
		MD_ABS_B       = 3'd2,
		MD_COMP        = 3'd3,
		MD_LAST        = 3'd4,
		MD_CHANGE_SIGN = 3'd5,
		MD_FINISH      = 3'd6
	} md_state_e;

endpackage

// ==== verilog/div_ctrl_if.sv ====
`timescale 1ns/1ps

interface div_ctrl_if;

	muldiv_pkg::md_state_e state;
	logic div_by_zero;
	logic [muldiv_pkg::CNT_W-1:0] bit_idx; // Quotient bit decided in this cycle.
	logic cnt_last;

	modport seq (
		output state,
		input  div_by_zero,
		input  bit_idx,
		input  cnt_last
	);

	modport cnt (
		output bit_idx,
		output cnt_last,
		input  state
	);

	modport dp (
		output div_by_zero,
		input  state,
		input  bit_idx
	);

endinterface

// ==== verilog/mac_multiplier.sv ====
`timescale 1ns/1ps

module mac_multiplier (
	input  logic                          clk_i,
	input  logic                          rst_ni,
	input  logic                          mult_en_i,
	input  muldiv_pkg::md_op_e            operator_i,
	input  logic [1:0]                    signed_mode_i,
	input  logic [muldiv_pkg::XLEN-1:0]   op_a_i,
	input  logic [muldiv_pkg::XLEN-1:0]   op_b_i,
	output logic [muldiv_pkg::XLEN-1:0]   result_o,
	output logic                          valid_o
);

	localparam int XLEN = muldiv_pkg::XLEN;
	localparam int HALF_W = muldiv_pkg::HALF_W;
	localparam int ACC_W = muldiv_pkg::ACC_W;

	typedef enum logic [3:0] {
		PH_ALBL = 4'b0001,
		PH_ALBH = 4'b0010,
		PH_AHBL = 4'b0100,
		PH_AHBH = 4'b1000
	} phase_e;

	phase_e phase_q;
	phase_e phase_n;
	logic [ACC_W-1:0] acc_q;
	logic [ACC_W-1:0] acc_n;
	logic [ACC_W-1:0] accum;
	logic [HALF_W-1:0] mult_a;
	logic [HALF_W-1:0] mult_b;
	logic sign_a;
	logic sign_b;
	logic signed [ACC_W:0] mac_full;
	logic [ACC_W-1:0] mac_res;
	logic signed_mult;
	logic is_mull;

	assign signed_mult = signed_mode_i != 2'b00;
	assign is_mull = operator_i == muldiv_pkg::MD_OP_MULL;

	assign mac_full = $signed({sign_a, mult_a}) * $signed({sign_b, mult_b}) + $signed(accum);
	assign mac_res = mac_full[ACC_W-1:0];

	always_comb begin
		mult_a = op_a_i[HALF_W-1:0];
		mult_b = op_b_i[HALF_W-1:0];
		sign_a = 1'b0;
		sign_b = 1'b0;
		accum = '0;
		acc_n = mac_res;
		phase_n = phase_q;
		valid_o = 1'b0;
		case (phase_q)
			PH_ALBL: begin
				phase_n = PH_ALBH;
			end
			PH_ALBH: begin
				mult_b = op_b_i[XLEN-1:HALF_W];
				sign_b = signed_mode_i[muldiv_pkg::SIGN_B_BIT] & op_b_i[XLEN-1];
				accum = {{(ACC_W-HALF_W){1'b0}}, acc_q[XLEN-1:HALF_W]};
				if (is_mull) begin
					acc_n = {{(ACC_W-XLEN){1'b0}}, mac_res[HALF_W-1:0], acc_q[HALF_W-1:0]};
				end
				phase_n = PH_AHBL;
			end
			PH_AHBL: begin
				mult_a = op_a_i[XLEN-1:HALF_W];
				sign_a = signed_mode_i[muldiv_pkg::SIGN_A_BIT] & op_a_i[XLEN-1];
				if (is_mull) begin
					// Only the low half of this product reaches the low word.
					accum = {{(ACC_W-HALF_W){1'b0}}, acc_q[XLEN-1:HALF_W]};
					acc_n = {{(ACC_W-XLEN){1'b0}}, mac_res[HALF_W-1:0], acc_q[HALF_W-1:0]};
					valid_o = 1'b1;
					phase_n = PH_ALBL;
				end else begin
					accum = acc_q;
					phase_n = PH_AHBH;
				end
			end
			PH_AHBH: begin
				mult_a = op_a_i[XLEN-1:HALF_W];
				mult_b = op_b_i[XLEN-1:HALF_W];
				sign_a = signed_mode_i[muldiv_pkg::SIGN_A_BIT] & op_a_i[XLEN-1];
				sign_b = signed_mode_i[muldiv_pkg::SIGN_B_BIT] & op_b_i[XLEN-1];
				accum = {{HALF_W{signed_mult & acc_q[ACC_W-1]}}, acc_q[ACC_W-1:HALF_W]};
				valid_o = 1'b1;
				phase_n = PH_ALBL;
			end
			default: begin
				phase_n = PH_ALBL;
			end
		endcase
	end

	assign result_o = acc_n[XLEN-1:0]; // Taken from the adder output in the last phase.

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			phase_q <= PH_ALBL;
		end else if (mult_en_i) begin
			phase_q <= phase_n;
		end
	end

	always_ff @(posedge clk_i) begin
		if (mult_en_i) begin
			acc_q <= acc_n;
		end
	end

	phase_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot(phase_q));

endmodule

// ==== verilog/div_sequencer.sv ====
`timescale 1ns/1ps

module div_sequencer (
	input  logic    clk_i,
	input  logic    rst_ni,
	input  logic    div_en_i,
	div_ctrl_if.seq ctrl,
	output logic    valid_o
);

	muldiv_pkg::md_state_e state_q;
	muldiv_pkg::md_state_e state_n;

	always_comb begin
		state_n = state_q;
		case (state_q)
			muldiv_pkg::MD_IDLE: begin
				// A zero divisor leaves the preloaded result as it is.
				if (ctrl.div_by_zero) begin
					state_n = muldiv_pkg::MD_FINISH;
				end else begin
					state_n = muldiv_pkg::MD_ABS_A;
				end
			end
			muldiv_pkg::MD_ABS_A: begin
				state_n = muldiv_pkg::MD_ABS_B;
			end
			muldiv_pkg::MD_ABS_B: begin
				state_n = muldiv_pkg::MD_COMP;
			end
			muldiv_pkg::MD_COMP: begin
				if (ctrl.cnt_last) begin
					state_n = muldiv_pkg::MD_LAST; // Bit 0 is decided in MD_LAST.
				end
			end
			muldiv_pkg::MD_LAST: begin
				state_n = muldiv_pkg::MD_CHANGE_SIGN;
			end
			muldiv_pkg::MD_CHANGE_SIGN: begin
				state_n = muldiv_pkg::MD_FINISH;
			end
			muldiv_pkg::MD_FINISH: begin
				state_n = muldiv_pkg::MD_IDLE;
			end
			default: begin
				state_n = muldiv_pkg::MD_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= muldiv_pkg::MD_IDLE;
		end else if (div_en_i) begin
			state_q <= state_n;
		end
	end

	assign ctrl.state = state_q;
	assign valid_o = state_q == muldiv_pkg::MD_FINISH;

	state_legal_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
		state_q inside {muldiv_pkg::MD_IDLE, muldiv_pkg::MD_ABS_A, muldiv_pkg::MD_ABS_B,
			muldiv_pkg::MD_COMP, muldiv_pkg::MD_LAST, muldiv_pkg::MD_CHANGE_SIGN,
			muldiv_pkg::MD_FINISH});

	// The last step is entered only from the compare loop, with the counter at bit 0.
	last_after_comp_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(state_q == muldiv_pkg::MD_LAST && $changed(state_q)) |->
			($past(state_q) == muldiv_pkg::MD_COMP && ctrl.bit_idx == '0));

endmodule

// ==== verilog/div_bit_counter.sv ====
`timescale 1ns/1ps

module div_bit_counter (
	input  logic    clk_i,
	input  logic    rst_ni,
	input  logic    div_en_i,
	div_ctrl_if.cnt ctrl
);

	localparam int CNT_W = muldiv_pkg::CNT_W;

	logic [CNT_W-1:0] cnt_q;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			cnt_q <= '0;
		end else if (div_en_i) begin
			if (ctrl.state inside {muldiv_pkg::MD_IDLE, muldiv_pkg::MD_ABS_A,
					muldiv_pkg::MD_ABS_B}) begin
				cnt_q <= CNT_W'(muldiv_pkg::XLEN - 1); // The MSB is decided first.
			end else begin
				cnt_q <= cnt_q - CNT_W'(1);
			end
		end
	end

	assign ctrl.bit_idx = cnt_q;
	assign ctrl.cnt_last = cnt_q == CNT_W'(1);

	cnt_no_wrap_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
		ctrl.state == muldiv_pkg::MD_COMP |-> cnt_q != '0);

endmodule

// ==== verilog/div_datapath.sv ====
`timescale 1ns/1ps

module div_datapath (
	input  logic                          clk_i,
	input  logic                          rst_ni,
	input  logic                          div_en_i,
	input  muldiv_pkg::md_op_e            operator_i,
	input  logic [1:0]                    signed_mode_i,
	input  logic [muldiv_pkg::XLEN-1:0]   op_a_i,
	input  logic [muldiv_pkg::XLEN-1:0]   op_b_i,
	div_ctrl_if.dp                        ctrl,
	output logic [muldiv_pkg::XLEN-1:0]   result_o
);

	localparam int XLEN = muldiv_pkg::XLEN;
	localparam int CNT_W = muldiv_pkg::CNT_W;

	logic [XLEN-1:0] numer_q;
	logic [XLEN-1:0] numer_n;
	logic [XLEN-1:0] denom_q;
	logic [XLEN-1:0] denom_n;
	logic [XLEN-1:0] quot_q;
	logic [XLEN-1:0] quot_n;
	logic [XLEN-1:0] rem_q;
	logic [XLEN-1:0] rem_n;
	logic [XLEN-1:0] adder_a;
	logic [XLEN-1:0] adder_b;
	logic [XLEN:0] adder_res;
	logic [XLEN-1:0] next_rem;
	logic [XLEN-1:0] next_quot;
	logic [XLEN-1:0] one_shift;
	logic [CNT_W-1:0] next_idx;
	logic is_div;
	logic is_ge;
	logic sign_a;
	logic sign_b;
	logic neg_result;

	assign is_div = operator_i == muldiv_pkg::MD_OP_DIV;
	assign sign_a = op_a_i[XLEN-1] & signed_mode_i[muldiv_pkg::SIGN_A_BIT];
	assign sign_b = op_b_i[XLEN-1] & signed_mode_i[muldiv_pkg::SIGN_B_BIT];
	assign neg_result = is_div ? (sign_a ^ sign_b) : sign_a; // Remainder follows the dividend.

	assign ctrl.div_by_zero = op_b_i == '0;

	// Computes a - b, the carry out is set when a >= b unsigned.
	assign adder_res = {1'b0, adder_a} + {1'b0, ~adder_b} + (XLEN+1)'(1);
	assign is_ge = adder_res[XLEN];

	always_comb begin
		adder_a = '0;
		adder_b = op_b_i;
		case (ctrl.state)
			muldiv_pkg::MD_ABS_A: begin
				adder_b = op_a_i;
			end
			muldiv_pkg::MD_COMP, muldiv_pkg::MD_LAST: begin
				adder_a = rem_q;
				adder_b = denom_q;
			end
			muldiv_pkg::MD_CHANGE_SIGN: begin
				adder_b = rem_q;
			end
			default: begin
				adder_b = op_b_i;
			end
		endcase
	end

	assign one_shift = XLEN'(1) << ctrl.bit_idx;
	assign next_quot = is_ge ? (quot_q | one_shift) : quot_q;
	assign next_rem = is_ge ? adder_res[XLEN-1:0] : rem_q;
	assign next_idx = ctrl.bit_idx - CNT_W'(1);

	always_comb begin
		numer_n = numer_q;
		denom_n = denom_q;
		quot_n = quot_q;
		rem_n = rem_q;
		case (ctrl.state)
			muldiv_pkg::MD_IDLE: begin
				rem_n = is_div ? '1 : op_a_i;
			end
			muldiv_pkg::MD_ABS_A: begin
				quot_n = '0;
				numer_n = sign_a ? adder_res[XLEN-1:0] : op_a_i;
			end
			muldiv_pkg::MD_ABS_B: begin
				rem_n = {{(XLEN-1){1'b0}}, numer_q[XLEN-1]};
				denom_n = sign_b ? adder_res[XLEN-1:0] : op_b_i;
			end
			muldiv_pkg::MD_COMP: begin
				rem_n = {next_rem[XLEN-2:0], numer_q[next_idx]};
				quot_n = next_quot;
			end
			muldiv_pkg::MD_LAST: begin
				rem_n = is_div ? next_quot : next_rem;
			end
			muldiv_pkg::MD_CHANGE_SIGN: begin
				rem_n = neg_result ? adder_res[XLEN-1:0] : rem_q;
			end
			default: begin
				rem_n = rem_q;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			rem_q <= '0;
		end else if (div_en_i) begin
			rem_q <= rem_n;
		end
	end

	always_ff @(posedge clk_i) begin
		if (div_en_i) begin
			numer_q <= numer_n;
			denom_q <= denom_n;
			quot_q <= quot_n;
		end
	end

	assign result_o = rem_q;

endmodule

// ==== verilog/muldiv_top.sv ====
`timescale 1ns/1ps

module muldiv_top (
	input  logic                          clk_i,
	input  logic                          rst_ni,
	input  logic                          req_i,
	input  muldiv_pkg::md_op_e            operator_i,
	input  logic [1:0]                    signed_mode_i,
	input  logic [muldiv_pkg::XLEN-1:0]   op_a_i,
	input  logic [muldiv_pkg::XLEN-1:0]   op_b_i,
	output logic [muldiv_pkg::XLEN-1:0]   result_o,
	output logic                          valid_o
);

	logic mult_en;
	logic div_en;
	logic mult_valid;
	logic div_valid;
	logic [muldiv_pkg::XLEN-1:0] mult_result;
	logic [muldiv_pkg::XLEN-1:0] div_result;

	div_ctrl_if div_ctrl ();

	assign mult_en = req_i &&
		(operator_i inside {muldiv_pkg::MD_OP_MULL, muldiv_pkg::MD_OP_MULH});
	assign div_en = req_i &&
		(operator_i inside {muldiv_pkg::MD_OP_DIV, muldiv_pkg::MD_OP_REM});

	mac_multiplier mac_multiplier_i (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.mult_en_i     (mult_en),
		.operator_i    (operator_i),
		.signed_mode_i (signed_mode_i),
		.op_a_i        (op_a_i),
		.op_b_i        (op_b_i),
		.result_o      (mult_result),
		.valid_o       (mult_valid)
	);

	div_sequencer div_sequencer_i (
		.clk_i    (clk_i),
		.rst_ni   (rst_ni),
		.div_en_i (div_en),
		.ctrl     (div_ctrl.seq),
		.valid_o  (div_valid)
	);

	div_bit_counter div_bit_counter_i (
		.clk_i    (clk_i),
		.rst_ni   (rst_ni),
		.div_en_i (div_en),
		.ctrl     (div_ctrl.cnt)
	);

	div_datapath div_datapath_i (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.div_en_i      (div_en),
		.operator_i    (operator_i),
		.signed_mode_i (signed_mode_i),
		.op_a_i        (op_a_i),
		.op_b_i        (op_b_i),
		.ctrl          (div_ctrl.dp),
		.result_o      (div_result)
	);

	assign valid_o = mult_valid | div_valid;
	assign result_o = div_en ? div_result : mult_result;

endmodule

// ==== bench/muldiv_model.svh ====
`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

function automatic logic [31:0] model_result(input muldiv_pkg::md_op_e op,
		input logic [1:0] mode, input logic [31:0] a, input logic [31:0] b);
	logic [63:0] ext_a;
	logic [63:0] ext_b;
	logic [63:0] product;
	logic div_signed;
	ext_a = mode[muldiv_pkg::SIGN_A_BIT] ? {{32{a[31]}}, a} : {32'd0, a};
	ext_b = mode[muldiv_pkg::SIGN_B_BIT] ? {{32{b[31]}}, b} : {32'd0, b};
	product = ext_a * ext_b; // Low 64 bits of the product are exact in two's complement.
	div_signed = mode == 2'b11;
	if (op == muldiv_pkg::MD_OP_MULL) begin
		return product[31:0];
	end
	if (op == muldiv_pkg::MD_OP_MULH) begin
		return product[63:32];
	end
	if (b == 32'd0) begin
		return (op == muldiv_pkg::MD_OP_DIV) ? 32'hffff_ffff : a;
	end
	if (div_signed && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
		return (op == muldiv_pkg::MD_OP_DIV) ? 32'h8000_0000 : 32'd0;
	end
	if (div_signed) begin
		// Both operators truncate toward zero, so the remainder keeps the dividend sign.
		if (op == muldiv_pkg::MD_OP_DIV) begin
			return $signed(a) / $signed(b);
		end
		return $signed(a) % $signed(b);
	end
	if (op == muldiv_pkg::MD_OP_DIV) begin
		return a / b;
	end
	return a % b;
endfunction

function automatic int model_latency(input muldiv_pkg::md_op_e op, input logic [31:0] b);
	if (op == muldiv_pkg::MD_OP_MULL) begin
		return 3;
	end
	if (op == muldiv_pkg::MD_OP_MULH) begin
		return 4;
	end
	if (b == 32'd0) begin
		return 2;
	end
	return 37; // Idle, two abs steps, 31 compares, last, sign change and finish.
endfunction

`endif

// ==== bench/muldiv_tb.sv ====
`timescale 1ns/1ps

module muldiv_tb;

	localparam int CLK_HALF = 2;
	localparam int DRIVE_DLY = 1;
	localparam int N_MUL = 40;
	localparam int N_MULH = 60;
	localparam int N_DIV = 60;
	localparam int N_CORNER = 6;
	localparam int N_B2B = 30;
	localparam int N_OPS = N_MUL + N_MULH + N_DIV + N_CORNER + N_B2B;
	localparam int MAX_WAIT = 40;

	logic clk_i;
	logic rst_ni;
	logic req_i;
	muldiv_pkg::md_op_e operator_i;
	logic [1:0] signed_mode_i;
	logic [muldiv_pkg::XLEN-1:0] op_a_i;
	logic [muldiv_pkg::XLEN-1:0] op_b_i;
	logic [muldiv_pkg::XLEN-1:0] result_o;
	logic valid_o;
	logic [31:0] lfsr_q;

	`include "muldiv_model.svh"

	muldiv_top dut_i (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.req_i         (req_i),
		.operator_i    (operator_i),
		.signed_mode_i (signed_mode_i),
		.op_a_i        (op_a_i),
		.op_b_i        (op_b_i),
		.result_o      (result_o),
		.valid_o       (valid_o)
	);

	always #(CLK_HALF) clk_i = ~clk_i;

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0]) begin
			next = next ^ 32'h8020_0003;
		end
		return next;
	endfunction

	task automatic take_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			value = {value[30:0], lfsr_q[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s expected %08h actual %08h", name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "Check failed in %s.", name);
		end
	endtask

	// Called one drive delay after a rising edge, returns at the same point of a later cycle.
	task automatic run_op(input string name, input muldiv_pkg::md_op_e op,
			input logic [1:0] mode, input logic [31:0] a, input logic [31:0] b);
		int cycles;
		req_i = 1'b1;
		operator_i = op;
		signed_mode_i = mode;
		op_a_i = a;
		op_b_i = b;
		cycles = 0;
		do begin
			@(negedge clk_i); // Cycle n ends at the n-th edge that samples the request.
			cycles++;
		end while (!valid_o && cycles < MAX_WAIT);
		if (!valid_o) begin
			$display("%s: valid_o did not rise within %0d cycles.", name, MAX_WAIT);
			$display("SIMULATION FAILED");
			$fatal(1, "No valid pulse.");
		end
		check_value({name, " result"}, model_result(op, mode, a, b), result_o);
		check_value({name, " latency"}, 32'(model_latency(op, b)), 32'(cycles));
		@(posedge clk_i);
		#(DRIVE_DLY);
	endtask

	task automatic release_req();
		req_i = 1'b0;
		@(negedge clk_i);
		check_value("valid pulse width", 32'd0, {31'd0, valid_o});
		@(posedge clk_i);
		#(DRIVE_DLY);
	endtask

	initial begin
		#(N_OPS * MAX_WAIT * 2 * CLK_HALF + 200);
		$display("Watchdog expired before the test sequence finished.");
		$display("SIMULATION FAILED");
		$fatal(1, "Timeout.");
	end

	initial begin
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sel;
		logic [31:0] shift;
		logic [1:0] mode;
		muldiv_pkg::md_op_e op;
		clk_i = 1'b0;
		rst_ni = 1'b0;
		req_i = 1'b0;
		operator_i = muldiv_pkg::MD_OP_MULL;
		signed_mode_i = 2'b00;
		op_a_i = '0;
		op_b_i = '0;
		lfsr_q = 32'hdd0c_932b;
		repeat (3) @(posedge clk_i);
		#(DRIVE_DLY);
		rst_ni = 1'b1;

		repeat (10) begin
			@(negedge clk_i);
			check_value("idle after reset", 32'd0, {31'd0, valid_o});
		end
		@(posedge clk_i);
		#(DRIVE_DLY);

		for (int i = 0; i < N_MUL; i++) begin
			take_bits(32, a);
			take_bits(32, b);
			take_bits(2, sel);
			run_op($sformatf("mul %0d", i), muldiv_pkg::MD_OP_MULL, sel[1:0], a, b);
			release_req();
		end

		for (int i = 0; i < N_MULH; i++) begin
			take_bits(32, a);
			take_bits(32, b);
			case (i % 3)
				0: mode = 2'b11;
				1: mode = 2'b01;
				default: mode = 2'b00;
			endcase
			run_op($sformatf("mulh %0d mode %b", i, mode), muldiv_pkg::MD_OP_MULH, mode, a, b);
			release_req();
		end

		for (int i = 0; i < N_DIV; i++) begin
			take_bits(32, a);
			take_bits(32, b);
			take_bits(5, shift);
			take_bits(2, sel);
			b = b >> shift; // Small divisors give quotients of every length.
			if (b == 32'd0) begin
				b = 32'd1;
			end
			op = sel[0] ? muldiv_pkg::MD_OP_REM : muldiv_pkg::MD_OP_DIV;
			mode = {sel[1], sel[1]};
			run_op($sformatf("div %0d op %0d mode %b", i, op, mode), op, mode, a, b);
			release_req();
		end

		take_bits(32, a);
		run_op("div by zero unsigned", muldiv_pkg::MD_OP_DIV, 2'b00, a, 32'd0);
		release_req();
		run_op("rem by zero unsigned", muldiv_pkg::MD_OP_REM, 2'b00, a, 32'd0);
		release_req();
		run_op("div by zero signed", muldiv_pkg::MD_OP_DIV, 2'b11, a, 32'd0);
		release_req();
		run_op("rem by zero signed", muldiv_pkg::MD_OP_REM, 2'b11, a, 32'd0);
		release_req();
		run_op("div overflow", muldiv_pkg::MD_OP_DIV, 2'b11, 32'h8000_0000, 32'hffff_ffff);
		release_req();
		run_op("rem overflow", muldiv_pkg::MD_OP_REM, 2'b11, 32'h8000_0000, 32'hffff_ffff);
		release_req();

		// No idle cycle between these requests.
		for (int i = 0; i < N_B2B; i++) begin
			take_bits(32, a);
			take_bits(32, b);
			take_bits(5, shift);
			take_bits(7, sel);
			op = muldiv_pkg::md_op_e'(sel[1:0]);
			mode = sel[3:2];
			if (op == muldiv_pkg::MD_OP_DIV || op == muldiv_pkg::MD_OP_REM) begin
				mode = {sel[2], sel[2]};
				b = (sel[6:4] == 3'd0) ? 32'd0 : b >> shift;
			end else if (mode == 2'b10) begin
				mode = 2'b11;
			end
			run_op($sformatf("back to back %0d op %0d mode %b", i, op, mode), op, mode, a, b);
		end
		release_req();

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== muldiv.f ====
+incdir+bench
verilog/muldiv_pkg.sv
verilog/div_ctrl_if.sv
verilog/mac_multiplier.sv
verilog/div_sequencer.sv
verilog/div_bit_counter.sv
verilog/div_datapath.sv
verilog/muldiv_top.sv
bench/muldiv_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module muldiv_tb -f muldiv.f -o muldiv_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
	echo "Verilator build returned status $build_status."
	exit "$build_status"
fi

./obj_dir/muldiv_sim
run_status=$?
if [ "$run_status" -ne 0 ]; then
	echo "Simulation run returned status $run_status."
	exit "$run_status"
fi

echo "Simulation run returned status 0."
exit 0
